/* src/etx_pkg.sv */
`default_nettype none

package etx_pkg;

   //##############################
   //# Sequencer states
   //##############################
   typedef enum logic [2:0]
   {
      TX_RESET_ALL      = 3'd0,
      TX_START_CCLK     = 3'd1,
      TX_STOP_CCLK      = 3'd2,
      TX_DEASSERT_RESET = 3'd3,
      TX_HOLD_IT        = 3'd4,
      TX_ACTIVE         = 3'd5
   } tx_state_t;

   //##############################
   //# Register map
   //##############################
   localparam logic [7:0] ADDR_CTRL   = 8'h00; // Soft reset in bit 0
   localparam logic [7:0] ADDR_HBPER  = 8'h04; // Heartbeat period
   localparam logic [7:0] ADDR_STATUS = 8'h08; // Read only

   localparam int HB_W = 8;
   localparam logic [HB_W-1:0] HBPER_RESET = 8'd15;
   localparam logic CTRL_RESET = 1'b1; // Sequence parked until software clears it

   // Status word layout, state sits in bits 2:0
   localparam int STAT_LOCK_BIT   = 3;
   localparam int STAT_ACTIVE_BIT = 4;

   //##############################
   //# Generator model timing
   //##############################
   localparam int LOCK_DELAY  = 20; // sys_clk cycles from reset release to lock
   localparam int LOCK_CNT_W  = $clog2(LOCK_DELAY);

endpackage

`default_nettype wire

/* src/etx_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface etx_ctrl_if;

   // Control from software
   logic                        soft_reset;
   logic [etx_pkg::HB_W-1:0]    hb_period;

   // Status back from the sequencer
   etx_pkg::tx_state_t          state;
   logic                        locked;   // Lock after the two flop sync
   logic                        active;

   modport regs
   (
      output soft_reset, hb_period,
      input  state, locked, active
   );

   modport fsm
   (
      input  soft_reset,
      output state, locked, active
   );

   // Heartbeat only needs the period
   modport tmr
   (
      input  hb_period
   );

endinterface

`default_nettype wire

/* src/etx_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_apb_regs
(
   input  wire logic        sys_clk,
   input  wire logic        sys_nreset,
   input  wire logic        psel,
   input  wire logic        penable,
   input  wire logic        pwrite,
   input  wire logic [7:0]  paddr,
   input  wire logic [31:0] pwdata,
   output logic      [31:0] prdata,
   output logic             pslverr,
   etx_ctrl_if.regs         ctrl
);

   logic        setup_ph;
   logic        access_ph;
   logic        addr_ok;
   logic        acc_err;
   logic [31:0] rd_data;

   assign setup_ph  = psel & ~penable;
   assign access_ph = psel & penable;

   //##############################
   //# Address decode
   //##############################
   always_comb
   begin
      rd_data = '0;
      addr_ok = 1'b1;
      case (paddr)
         etx_pkg::ADDR_CTRL  : rd_data[0] = ctrl.soft_reset;
         etx_pkg::ADDR_HBPER : rd_data[etx_pkg::HB_W-1:0] = ctrl.hb_period;
         etx_pkg::ADDR_STATUS :
         begin
            rd_data[2:0]                     = ctrl.state;
            rd_data[etx_pkg::STAT_LOCK_BIT]   = ctrl.locked;
            rd_data[etx_pkg::STAT_ACTIVE_BIT] = ctrl.active;
         end
         default : addr_ok = 1'b0;
      endcase
   end

   // Status is read only
   assign acc_err = ~addr_ok | (pwrite & (paddr == etx_pkg::ADDR_STATUS));

   // Response captured in setup, held through access
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end
      else if (setup_ph)
      begin
         prdata  <= pwrite ? 32'd0 : rd_data;
         pslverr <= acc_err;
      end
      else
      begin
         prdata  <= '0;  // Back to zero once access ends
         pslverr <= 1'b0;
      end
   end

   //##############################
   //# Control registers
   //##############################
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         ctrl.soft_reset <= etx_pkg::CTRL_RESET;
         ctrl.hb_period  <= etx_pkg::HBPER_RESET;
      end
      else if (access_ph & pwrite & ~acc_err)
      begin
         if (paddr == etx_pkg::ADDR_CTRL)
            ctrl.soft_reset <= pwdata[0];
         if (paddr == etx_pkg::ADDR_HBPER)
            ctrl.hb_period <= pwdata[etx_pkg::HB_W-1:0];
      end
   end

endmodule

`default_nettype wire

/* src/etx_heartbeat.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_heartbeat
(
   input  wire logic   sys_clk,
   input  wire logic   sys_nreset,
   etx_ctrl_if.tmr     ctrl,
   output logic        tick
);

   logic [etx_pkg::HB_W-1:0] count;

   // Counts hb_period down to zero, so one tick per hb_period+1 cycles
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         count <= '0;
      else if (count == '0)
         count <= ctrl.hb_period;  // New period only picked up here
      else
         count <= count - 1'b1;
   end

   assign tick = (count == '0);

endmodule

`default_nettype wire

/* src/etx_reset_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_reset_fsm
(
   input  wire logic   sys_clk,
   input  wire logic   sys_nreset,
   input  wire logic   tick,
   input  wire logic   gen_locked,
   etx_ctrl_if.fsm     ctrl,
   output logic        gen_reset,
   output logic        chip_nreset,
   output logic        link_nreset
);

   etx_pkg::tx_state_t state;
   logic               lock_meta;
   logic               lock_sync;

   // Lock comes from the generator, treat it as async
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end
      else if (gen_reset)
      begin
         lock_meta <= 1'b0;  // Forget the lock from before this generator reset
         lock_sync <= 1'b0;
      end
      else
      begin
         lock_meta <= gen_locked;
         lock_sync <= lock_meta;
      end
   end

   //##############################
   //# Sequencer
   //##############################
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         state <= etx_pkg::TX_RESET_ALL;
      else if (tick)
      begin
         case (state)
            etx_pkg::TX_RESET_ALL :
               if (!ctrl.soft_reset)
                  state <= etx_pkg::TX_START_CCLK;
            etx_pkg::TX_START_CCLK :
               if (lock_sync)
                  state <= etx_pkg::TX_STOP_CCLK;
            etx_pkg::TX_STOP_CCLK :
               state <= etx_pkg::TX_DEASSERT_RESET;
            etx_pkg::TX_DEASSERT_RESET :
               state <= etx_pkg::TX_HOLD_IT;
            etx_pkg::TX_HOLD_IT :
               if (lock_sync)  // Relock after the second generator reset
                  state <= etx_pkg::TX_ACTIVE;
            etx_pkg::TX_ACTIVE :
               if (ctrl.soft_reset)
                  state <= etx_pkg::TX_RESET_ALL;
            default :
               state <= etx_pkg::TX_RESET_ALL;
         endcase
      end
   end

   //##############################
   //# Reset decode
   //##############################
   assign gen_reset = (state == etx_pkg::TX_RESET_ALL) |
                      (state == etx_pkg::TX_STOP_CCLK) |
                      (state == etx_pkg::TX_DEASSERT_RESET);

   // Far chip out of reset before the link
   assign chip_nreset = (state == etx_pkg::TX_DEASSERT_RESET) |
                        (state == etx_pkg::TX_HOLD_IT) |
                        (state == etx_pkg::TX_ACTIVE);

   assign link_nreset = (state == etx_pkg::TX_ACTIVE);

   assign ctrl.state  = state;
   assign ctrl.locked = lock_sync;
   assign ctrl.active = (state == etx_pkg::TX_ACTIVE);

endmodule

`default_nettype wire

/* src/etx_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_clkgen
(
   input  wire logic   sys_clk,
   input  wire logic   sys_nreset,
   input  wire logic   gen_reset,
   input  wire logic   link_nreset,
   output logic        gen_locked,
   output logic        tx_lclk_io,
   output logic        tx_lclk_div4,
   output logic        cclk,
   output logic        etx_nreset,
   output logic        etx_io_nreset
);

   logic [etx_pkg::LOCK_CNT_W-1:0] lock_cnt;
   logic                           clk_en;
   logic [1:0]                     div_cnt;
   logic [1:0]                     core_pipe;
   logic [1:0]                     io_pipe;

   //##############################
   //# Lock model
   //##############################
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         lock_cnt   <= '0;
         gen_locked <= 1'b0;
      end
      else if (gen_reset)
      begin
         lock_cnt   <= '0;
         gen_locked <= 1'b0;
      end
      else if (!gen_locked)
      begin
         lock_cnt   <= lock_cnt + 1'b1;
         gen_locked <= (lock_cnt == etx_pkg::LOCK_CNT_W'(etx_pkg::LOCK_DELAY - 1));
      end
   end

   // Latch based gate keeps the gated clocks free of runt pulses
   always_latch
   begin
      if (!sys_clk)
         clk_en = gen_locked;
   end

   assign tx_lclk_io = sys_clk & clk_en;
   assign cclk       = sys_clk & clk_en;

   // Quarter rate logic clock, held low while unlocked
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         div_cnt <= 2'b00;
      else if (!gen_locked)
         div_cnt <= 2'b00;
      else
         div_cnt <= div_cnt + 2'b01;
   end

   assign tx_lclk_div4 = div_cnt[1];

   //##############################
   //# Reset synchronizers
   //##############################
   always_ff @(posedge tx_lclk_div4 or negedge link_nreset)
   begin
      if (!link_nreset)
         core_pipe <= 2'b00;
      else
         core_pipe <= {core_pipe[0], 1'b1};
   end

   always_ff @(posedge tx_lclk_io or negedge link_nreset)
   begin
      if (!link_nreset)
         io_pipe <= 2'b00;
      else
         io_pipe <= {io_pipe[0], 1'b1};
   end

   assign etx_nreset    = core_pipe[1];
   assign etx_io_nreset = io_pipe[1];  // Fast IO domain

endmodule

`default_nettype wire

/* src/etx_clocks_top.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_clocks_top
(
   input  wire logic        sys_clk,
   input  wire logic        sys_nreset,
   input  wire logic        psel,
   input  wire logic        penable,
   input  wire logic        pwrite,
   input  wire logic [7:0]  paddr,
   input  wire logic [31:0] pwdata,
   output logic      [31:0] prdata,
   output logic             pslverr,
   output logic             tx_lclk_io,
   output logic             tx_lclk_div4,
   output logic             cclk,
   output logic             chip_nreset,
   output logic             etx_nreset,
   output logic             etx_io_nreset,
   output logic             tx_active
);

   logic tick;
   logic gen_reset;
   logic gen_locked;
   logic link_nreset;

   etx_ctrl_if ctrl_if ();

   etx_apb_regs u_regs
   (
      .sys_clk    (sys_clk),
      .sys_nreset (sys_nreset),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pslverr    (pslverr),
      .ctrl       (ctrl_if.regs)
   );

   etx_heartbeat u_heartbeat
   (
      .sys_clk    (sys_clk),
      .sys_nreset (sys_nreset),
      .ctrl       (ctrl_if.tmr),
      .tick       (tick)
   );

   etx_reset_fsm u_fsm
   (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .tick        (tick),
      .gen_locked  (gen_locked),
      .ctrl        (ctrl_if.fsm),
      .gen_reset   (gen_reset),
      .chip_nreset (chip_nreset),
      .link_nreset (link_nreset)
   );

   etx_clkgen u_clkgen
   (
      .sys_clk       (sys_clk),
      .sys_nreset    (sys_nreset),
      .gen_reset     (gen_reset),
      .link_nreset   (link_nreset),
      .gen_locked    (gen_locked),
      .tx_lclk_io    (tx_lclk_io),
      .tx_lclk_div4  (tx_lclk_div4),
      .cclk          (cclk),
      .etx_nreset    (etx_nreset),
      .etx_io_nreset (etx_io_nreset)
   );

   assign tx_active = ctrl_if.active;

endmodule

`default_nettype wire

/* testbench/etx_clocks_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_clocks_chk
(
   input  wire logic       sys_clk,
   input  wire logic       sys_nreset,
   input  wire logic       tick,
   input  wire logic [2:0] state,
   input  wire logic       gen_reset,
   input  wire logic       chip_nreset,
   input  wire logic       tx_active,
   input  wire logic       locked
);

   int fail_count = 0;

   chip_before_active : assert property (@(posedge sys_clk) disable iff (!sys_nreset)
      tx_active |-> chip_nreset)
      else
      begin
         $error("chip_nreset low while tx_active high");
         fail_count = fail_count + 1;
      end

   // A state change must follow a heartbeat tick
   state_moves_on_tick : assert property (@(posedge sys_clk) disable iff (!sys_nreset)
      (state != $past(state)) |-> $past(tick))
      else
      begin
         $error("sequencer state changed without a tick");
         fail_count = fail_count + 1;
      end

   no_active_in_gen_reset : assert property (@(posedge sys_clk) disable iff (!sys_nreset)
      !(tx_active && gen_reset))
      else
      begin
         $error("tx_active high while the generator is held in reset");
         fail_count = fail_count + 1;
      end

   // Link only goes up on a fresh lock
   active_needs_lock : assert property (@(posedge sys_clk) disable iff (!sys_nreset)
      tx_active |-> locked)
      else
      begin
         $error("tx_active high while the generator lock is clear");
         fail_count = fail_count + 1;
      end

endmodule

`default_nettype wire

/* testbench/etx_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_monitor
(
   input  wire logic        sys_clk,
   input  wire logic        sys_nreset,
   input  wire logic [31:0] prdata,
   input  wire logic        pslverr,
   input  wire logic        tx_active,
   input  wire logic        chip_nreset,
   input  wire logic        etx_nreset,
   input  wire logic        etx_io_nreset,
   input  wire logic        tx_lclk_io,
   input  wire logic        tx_lclk_div4,
   input  wire logic        cclk
);

   int value_errors = 0;
   int order_errors = 0;

   // Running edge counts of the generated clocks
   int io_edges   = 0;
   int cclk_edges = 0;
   int div4_edges = 0;
   int io_mark    = 0;
   int cclk_mark  = 0;
   int div4_mark  = 0;

   always @(posedge tx_lclk_io)
      io_edges = io_edges + 1;

   always @(posedge cclk)
      cclk_edges = cclk_edges + 1;

   always @(posedge tx_lclk_div4)
      div4_edges = div4_edges + 1;

   // Called during the APB access phase
   task automatic check_apb(input string name, input logic [31:0] exp_data,
                            input logic check_data, input logic exp_err);
      if (pslverr !== exp_err)
      begin
         $display("FAIL %s pslverr expected %0b actual %0b", name, exp_err, pslverr);
         value_errors = value_errors + 1;
      end
      if (check_data && prdata !== exp_data)
      begin
         $display("FAIL %s prdata expected %h actual %h", name, exp_data, prdata);
         value_errors = value_errors + 1;
      end
   endtask

   // Bit order etx_io_nreset, etx_nreset, chip_nreset, tx_active
   function automatic logic ports_match(input logic [3:0] exp_ports);
      return ({etx_io_nreset, etx_nreset, chip_nreset, tx_active} === exp_ports);
   endfunction

   task automatic check_ports(input string name, input logic [3:0] exp_ports);
      if (!ports_match(exp_ports))
      begin
         $display("FAIL %s reset outputs expected %b actual %b", name, exp_ports,
                  {etx_io_nreset, etx_nreset, chip_nreset, tx_active});
         value_errors = value_errors + 1;
      end
   endtask

   task automatic mark_clocks();
      io_mark   = io_edges;
      cclk_mark = cclk_edges;
      div4_mark = div4_edges;
   endtask

   // Fast clocks follow sys_clk, the logic clock runs at a quarter of it
   task automatic check_clocks(input string name, input logic running, input int cycles);
      int exp_fast;
      int exp_div4;
      exp_fast = running ? cycles : 0;
      exp_div4 = running ? cycles / 4 : 0;
      if (io_edges - io_mark != exp_fast)
      begin
         $display("FAIL %s tx_lclk_io edges expected %0d actual %0d", name, exp_fast,
                  io_edges - io_mark);
         value_errors = value_errors + 1;
      end
      if (cclk_edges - cclk_mark != exp_fast)
      begin
         $display("FAIL %s cclk edges expected %0d actual %0d", name, exp_fast,
                  cclk_edges - cclk_mark);
         value_errors = value_errors + 1;
      end
      if (div4_edges - div4_mark != exp_div4)
      begin
         $display("FAIL %s tx_lclk_div4 edges expected %0d actual %0d", name, exp_div4,
                  div4_edges - div4_mark);
         value_errors = value_errors + 1;
      end
   endtask

   // Far chip has to leave reset no later than the link goes active
   always @(negedge sys_clk)
   begin
      if (sys_nreset && tx_active && !chip_nreset)
      begin
         $display("Error at %0t: tx_active is high while chip_nreset is still low", $time);
         order_errors = order_errors + 1;
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_etx_clocks.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_etx_clocks;

   localparam int MAX_WORDS  = 200;  // Five words per step
   localparam int WAIT_LIMIT = 2000;
   localparam int CLK_WINDOW = 16;   // Whole number of div4 periods

   logic        sys_clk;
   logic        sys_nreset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pslverr;
   logic        tx_lclk_io;
   logic        tx_lclk_div4;
   logic        cclk;
   logic        chip_nreset;
   logic        etx_nreset;
   logic        etx_io_nreset;
   logic        tx_active;

   logic [31:0] test_mem [0:MAX_WORDS-1];
   int          step_errors;

   etx_clocks_top UUT
   (
      .sys_clk       (sys_clk),
      .sys_nreset    (sys_nreset),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pslverr       (pslverr),
      .tx_lclk_io    (tx_lclk_io),
      .tx_lclk_div4  (tx_lclk_div4),
      .cclk          (cclk),
      .chip_nreset   (chip_nreset),
      .etx_nreset    (etx_nreset),
      .etx_io_nreset (etx_io_nreset),
      .tx_active     (tx_active)
   );

   etx_monitor mon
   (
      .sys_clk       (sys_clk),
      .sys_nreset    (sys_nreset),
      .prdata        (prdata),
      .pslverr       (pslverr),
      .tx_active     (tx_active),
      .chip_nreset   (chip_nreset),
      .etx_nreset    (etx_nreset),
      .etx_io_nreset (etx_io_nreset),
      .tx_lclk_io    (tx_lclk_io),
      .tx_lclk_div4  (tx_lclk_div4),
      .cclk          (cclk)
   );

   // Sequencer rules checked inside the FSM
   bind etx_reset_fsm etx_clocks_chk u_chk
   (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .tick        (tick),
      .state       (state),
      .gen_reset   (gen_reset),
      .chip_nreset (chip_nreset),
      .tx_active   (ctrl.active),
      .locked      (ctrl.locked)
   );

   initial
   begin
      sys_clk = 1'b0;
      forever #2 sys_clk = ~sys_clk;
   end

   function automatic string test_name(input logic [7:0] code);
      case (code)
         8'h01   : return "reset_values";
         8'h02   : return "bring_up";
         8'h03   : return "soft_reset";
         8'h04   : return "fast_heartbeat";
         8'h05   : return "bad_access";
         default : return "unnamed";
      endcase
   endfunction

   //##############################
   //# APB and wait tasks
   //##############################
   task automatic apb_transfer(input string name, input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, input logic [31:0] exp_data,
                               input logic check_data, input logic exp_err);
      psel    = 1'b1;  // Setup phase
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge sys_clk);
      #1 penable = 1'b1;
      #1 mon.check_apb(name, exp_data, check_data, exp_err);  // Mid access phase
      @(posedge sys_clk);
      #1 psel = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic wait_active_level(input string name, input logic level);
      int cycles;
      cycles = 0;
      while (tx_active !== level && cycles < WAIT_LIMIT)
      begin
         @(posedge sys_clk);
         #1 cycles = cycles + 1;
      end
      if (tx_active !== level)
      begin
         $display("Timeout in %s: tx_active did not go to %0d within %0d cycles",
                  name, level, WAIT_LIMIT);
         step_errors = step_errors + 1;
      end
   endtask

   task automatic wait_ports(input string name, input logic [2:0] exp_ports);
      logic [3:0] exp_all;
      int         cycles;
      exp_all = {exp_ports[2], exp_ports};  // Both link domains leave reset together
      cycles  = 0;
      while (!mon.ports_match(exp_all) && cycles < WAIT_LIMIT)
      begin
         @(posedge sys_clk);
         #1 cycles = cycles + 1;
      end
      if (!mon.ports_match(exp_all))
      begin
         $display("Timeout in %s: reset outputs did not settle within %0d cycles",
                  name, WAIT_LIMIT);
         step_errors = step_errors + 1;
      end
      mon.check_ports(name, exp_all);
      // Gated clocks run with the link up and stop in full reset
      mon.mark_clocks();
      repeat (CLK_WINDOW) @(posedge sys_clk);
      #1 mon.check_clocks(name, exp_ports[0], CLK_WINDOW);
   endtask

   task automatic run_step(input string name, input logic [3:0] op, input logic [7:0] addr,
                           input logic [31:0] data, input logic [31:0] exp_val);
      case (op)
         4'h0 : apb_transfer(name, 1'b1, addr, data, 32'd0, 1'b0, 1'b0);
         4'h1 : apb_transfer(name, 1'b0, addr, 32'd0, exp_val, 1'b1, 1'b0);
         4'h2 : wait_active_level(name, 1'b1);
         4'h3 : wait_active_level(name, 1'b0);
         4'h4 : wait_ports(name, exp_val[2:0]);
         4'h5 : apb_transfer(name, 1'b1, addr, data, 32'd0, 1'b0, 1'b1);  // Bad write
         4'h6 : apb_transfer(name, 1'b0, addr, 32'd0, 32'd0, 1'b0, 1'b1);
         default :
         begin
            $display("Unknown operation %0h in step %s", op, name);
            step_errors = step_errors + 1;
         end
      endcase
   endtask

   //##############################
   //# Test sequence
   //##############################
   initial
   begin
      int idx;
      sys_nreset  = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = 8'h00;
      pwdata      = 32'd0;
      step_errors = 0;
      $readmemh("testbench/etx_tests.txt", test_mem);
      repeat (5) @(posedge sys_clk);
      #1 sys_nreset = 1'b1;
      idx = 0;
      while (idx + 4 < MAX_WORDS && test_mem[idx+1][3:0] != 4'hf)
      begin
         run_step(test_name(test_mem[idx][7:0]), test_mem[idx+1][3:0], test_mem[idx+2][7:0],
                  test_mem[idx+3], test_mem[idx+4]);
         idx = idx + 5;
      end
      if (idx == 0 || idx + 4 >= MAX_WORDS || test_mem[idx+1][3:0] !== 4'hf)
      begin
         $display("Test file did not load, holds no steps or has no end marker");
         step_errors = step_errors + 1;
      end
      $display("Errors: %0d value, %0d order, %0d step, %0d assertion", mon.value_errors,
               mon.order_errors, step_errors, UUT.u_fsm.u_chk.fail_count);
      if (mon.value_errors == 0 && mon.order_errors == 0 && step_errors == 0 &&
          UUT.u_fsm.u_chk.fail_count == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/etx_tests.txt */
// Columns: name op addr data expected, all hex
// Ops: 0 write, 1 read, 2 wait active, 3 wait idle, 4 outputs, 5 bad write, 6 bad read, f end
01 1 00 00000000 00000001
01 1 04 00000000 0000000f
01 1 08 00000000 00000000
01 4 00 00000000 00000000
02 0 00 00000000 00000000
02 2 00 00000000 00000000
02 1 08 00000000 0000001d
02 4 00 00000000 00000007
03 0 00 00000001 00000000
03 3 00 00000000 00000000
03 1 00 00000000 00000001
03 1 04 00000000 0000000f
03 1 08 00000000 00000000
03 4 00 00000000 00000000
04 0 04 00000000 00000000
04 1 04 00000000 00000000
04 0 00 00000000 00000000
04 2 00 00000000 00000000
04 4 00 00000000 00000007
04 1 08 00000000 0000001d
05 6 0c 00000000 00000000
05 5 08 00000001 00000000
05 1 00 00000000 00000000
05 1 04 00000000 00000000
05 1 08 00000000 0000001d
00 f 00 00000000 00000000

/* filelist.f */
src/etx_pkg.sv
src/etx_ctrl_if.sv
src/etx_apb_regs.sv
src/etx_heartbeat.sv
src/etx_reset_fsm.sv
src/etx_clkgen.sv
src/etx_clocks_top.sv
testbench/etx_clocks_chk.sv
testbench/etx_monitor.sv
testbench/tb_etx_clocks.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_etx_clocks -f filelist.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
   exit 1
fi
exit 0
